/* Makefile */
TOP := tbIobBridge
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "tests failed" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "all tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* build.f */
+incdir+src
src/iobPkg.sv
src/iobReqIf.sv
src/iobSlave.sv
src/iobMaster.sv
src/iobBridge.sv
tests/tbClock.sv
tests/tbIobBridge.sv

/* src/iobBridge.sv */
`timescale 1ns/1ps
`include "iobBridge_settings.svh"

module iobBridge (
	input  logic CLK,
	input  logic rstN,
	// FSB side
	input  logic asN,
	input  logic weN,
	input  logic ldsN,
	input  logic udsN,
	input  logic [`IOB_ADDR_W-1:0] fsbAddr,
	input  logic [`IOB_DATA_W-1:0] fsbWrData,
	output logic [`IOB_DATA_W-1:0] fsbRdData,
	input  logic ioCs,
	input  logic ioPwCs,
	output logic fsbReady,
	output logic berrN,
	// I/O side
	output logic [`IOB_ADDR_W-1:0] ioAddr,
	output logic [`IOB_DATA_W-1:0] ioWrData,
	input  logic [`IOB_DATA_W-1:0] ioRdData,
	output logic ioRw,
	output logic ioLds,
	output logic ioUds,
	output logic ioStrobe,
	input  logic ioAck,
	input  logic ioErr
);

	// Request channel from slave to master
	iobReqIf reqBus ();

	iobSlave uSlave (
		.CLK       (CLK),
		.rstN      (rstN),
		.asN       (asN),
		.weN       (weN),
		.ldsN      (ldsN),
		.udsN      (udsN),
		.fsbAddr   (fsbAddr),
		.fsbWrData (fsbWrData),
		.ioCs      (ioCs),
		.ioPwCs    (ioPwCs),
		.fsbReady  (fsbReady),
		.berrN     (berrN),
		.fsbRdData (fsbRdData),
		.bus       (reqBus.slave)
	);

	iobMaster uMaster (
		.CLK      (CLK),
		.rstN     (rstN),
		.bus      (reqBus.master),
		.ioAddr   (ioAddr),
		.ioWrData (ioWrData),
		.ioRdData (ioRdData),
		.ioRw     (ioRw),
		.ioLds    (ioLds),
		.ioUds    (ioUds),
		.ioStrobe (ioStrobe),
		.ioAck    (ioAck),
		.ioErr    (ioErr)
	);

endmodule

/* src/iobBridge_settings.svh */
`ifndef IOBBRIDGE_SETTINGS_SVH
`define IOBBRIDGE_SETTINGS_SVH

// FSB word address width
// Covers address bits 23 down to 1
`define IOB_ADDR_W 23

// FSB and I/O bus data width
`define IOB_DATA_W 16

// Cycles the master holds the strobe waiting for an acknowledge
// A cycle that runs out is ended as an error
`define IOB_TIMEOUT 16

`endif

/* src/iobMaster.sv */
`timescale 1ns/1ps
`include "iobBridge_settings.svh"

module iobMaster (
	input  logic CLK,
	input  logic rstN,
	iobReqIf.master bus,
	output logic [`IOB_ADDR_W-1:0] ioAddr,
	output logic [`IOB_DATA_W-1:0] ioWrData,
	input  logic [`IOB_DATA_W-1:0] ioRdData,
	output logic ioRw,
	output logic ioLds,
	output logic ioUds,
	output logic ioStrobe,
	input  logic ioAck,
	input  logic ioErr
);

	localparam int CntW = $clog2(`IOB_TIMEOUT + 1);

	// Strobe and act are the same state
	logic active;
	// Set at start until the slave drops req
	logic needRelease;
	logic [CntW-1:0] waitCnt;
	logic timedOut;
	logic endNow;

	// Last allowed strobe cycle
	assign timedOut = (waitCnt == CntW'(`IOB_TIMEOUT - 1));
	assign endNow = active && (ioAck || ioErr || timedOut);

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			active <= 1'b0;
			needRelease <= 1'b0;
			waitCnt <= '0;
			bus.err <= 1'b0;
		end else begin
			// Old req still high after a short cycle must not restart
			if (!bus.req)
				needRelease <= 1'b0;
			if (!active && bus.req && !needRelease) begin
				active <= 1'b1;
				needRelease <= 1'b1;
				waitCnt <= '0;
			end else if (endNow) begin
				active <= 1'b0;
				// No acknowledge at all means timeout
				bus.err <= ioErr || !ioAck;
			end else if (active) begin
				waitCnt <= waitCnt + 1'b1;
			end
		end
	end

	// Read data held until the next read completes
	always_ff @(posedge CLK) begin
		if (endNow && ioAck && !ioErr && bus.entry.rw)
			bus.rdData <= ioRdData;
	end

	assign bus.act = active;
	assign ioStrobe = active;

	// I/O bus follows the primary level
	assign ioAddr = bus.entry.addr;
	assign ioWrData = bus.entry.wrData;
	assign ioRw = bus.entry.rw;
	assign ioLds = bus.entry.lds;
	assign ioUds = bus.entry.uds;

	// Slave keeps the entry still for the whole strobe
	assert property (@(posedge CLK) disable iff (!rstN)
		ioStrobe |-> ($stable(ioAddr) && $stable(ioRw)));

endmodule

/* src/iobPkg.sv */
`include "iobBridge_settings.svh"

package iobPkg;

	// One queue entry as seen by the I/O bus master
	typedef struct packed {
		// Word address from the FSB
		logic [`IOB_ADDR_W-1:0] addr;
		// Write data, ignored on reads
		logic [`IOB_DATA_W-1:0] wrData;
		// Read when high, taken from the weN level
		logic rw;
		// Byte enables, active high
		logic lds;
		logic uds;
	} ioReq_t;

	// Slave transfer machine
	// Start latches the primary level and then waits for the master
	typedef enum logic [1:0] {
		xferIdle     = 2'd0,
		xferWaitDone = 2'd1,
		xferWaitAct  = 2'd2,
		xferStart    = 2'd3
	} xferState_t;

endpackage

/* src/iobReqIf.sv */
`timescale 1ns/1ps
`include "iobBridge_settings.svh"

// Request and active handshake between the FSB slave and the I/O master
interface iobReqIf;

	// Transfer request from the slave
	logic req;
	// High while the master runs the I/O cycle
	logic act;
	// Result of the last cycle
	// Valid from the fall of act until the next act
	logic err;
	logic [`IOB_DATA_W-1:0] rdData;
	// Primary queue level
	// Held stable from req until act falls
	iobPkg::ioReq_t entry;

	modport slave (
		output req,
		output entry,
		input  act,
		input  err,
		input  rdData
	);

	modport master (
		input  req,
		input  entry,
		output act,
		output err,
		output rdData
	);

endinterface

/* src/iobSlave.sv */
`timescale 1ns/1ps
`include "iobBridge_settings.svh"

module iobSlave (
	input  logic CLK,
	input  logic rstN,
	input  logic asN,
	input  logic weN,
	input  logic ldsN,
	input  logic udsN,
	input  logic [`IOB_ADDR_W-1:0] fsbAddr,
	input  logic [`IOB_DATA_W-1:0] fsbWrData,
	input  logic ioCs,
	input  logic ioPwCs,
	output logic fsbReady,
	output logic berrN,
	output logic [`IOB_DATA_W-1:0] fsbRdData,
	iobReqIf.slave bus
);

	// FSB cycle seen one clock after asN falls
	logic busActive;
	// Registered act from the master
	logic actR;
	// One request per FSB cycle
	logic sent;
	iobPkg::xferState_t state;

	// Secondary level holding one posted write
	logic secValid;
	iobPkg::ioReq_t secEntry;
	iobPkg::ioReq_t fsbEntry;

	// Cycle termination for non-posted accesses
	logic readyR;
	logic berrR;

	logic pwSel;
	logic npSel;
	logic startFsb;
	logic loadSec;
	logic termNow;

	// Posted writes only when the cycle really is a write
	assign pwSel = ioCs && ioPwCs && !weN;
	assign npSel = ioCs && !pwSel;

	// Request built straight from the FSB lines
	assign fsbEntry = '{addr: fsbAddr, wrData: fsbWrData, rw: weN,
		lds: !ldsN, uds: !udsN};

	// Idle with empty queue takes the FSB access into the primary level
	assign startFsb = (state == iobPkg::xferIdle) && busActive && ioCs &&
		!secValid && !sent;

	// Busy transfer lets a posted write park in the secondary level
	assign loadSec = (state != iobPkg::xferIdle) && busActive && pwSel &&
		!secValid && !sent;

	// Own transfer and all earlier writes are done
	assign termNow = busActive && npSel && sent && !secValid &&
		((state == iobPkg::xferIdle) ||
		((state == iobPkg::xferWaitDone) && !actR));

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			busActive <= 1'b0;
			actR <= 1'b0;
		end else begin
			busActive <= !asN;
			actR <= bus.act;
		end
	end

	// Transfer machine
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			state <= iobPkg::xferIdle;
			bus.req <= 1'b0;
		end else begin
			case (state)
				iobPkg::xferIdle: begin
					// Parked write goes first to keep writes in order
					if (secValid || startFsb) begin
						state <= iobPkg::xferStart;
						bus.req <= 1'b1;
					end
				end
				iobPkg::xferStart: begin
					state <= iobPkg::xferWaitAct;
				end
				iobPkg::xferWaitAct: begin
					// Master has taken the request
					if (actR) begin
						state <= iobPkg::xferWaitDone;
						bus.req <= 1'b0;
					end
				end
				default: begin
					// I/O cycle over once act is low again
					if (!actR)
						state <= iobPkg::xferIdle;
				end
			endcase
		end
	end

	// Primary and secondary payload
	always_ff @(posedge CLK) begin
		if ((state == iobPkg::xferIdle) && secValid)
			bus.entry <= secEntry;
		else if (startFsb)
			bus.entry <= fsbEntry;
		if (loadSec)
			secEntry <= fsbEntry;
	end

	// Secondary level empties in the start cycle that moved it up
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN)
			secValid <= 1'b0;
		else if (state == iobPkg::xferStart)
			secValid <= 1'b0;
		else if (loadSec)
			secValid <= 1'b1;
	end

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN)
			sent <= 1'b0;
		else if (!busActive)
			sent <= 1'b0;
		else if (startFsb || loadSec)
			sent <= 1'b1;
	end

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			readyR <= 1'b0;
			berrR <= 1'b0;
		end else if (!busActive) begin
			readyR <= 1'b0;
			berrR <= 1'b0;
		end else if (termNow) begin
			// Master error becomes a bus error
			readyR <= !bus.err;
			berrR <= bus.err;
		end
	end

	always_ff @(posedge CLK) begin
		if (termNow)
			fsbRdData <= bus.rdData;
	end

	// Posted write acked once it sits in a queue level
	// Gated by asN so the outputs drop as soon as the cycle ends
	assign fsbReady = !asN && busActive &&
		((pwSel && sent) || (npSel && readyR));
	assign berrN = !(!asN && busActive && npSel && berrR);

	// Request withdrawn only after the master went active
	assert property (@(posedge CLK) disable iff (!rstN)
		$fell(bus.req) |-> $past(bus.act, 2));

	// Non-posted end only with the queue drained, ready or bus error but not both
	assert property (@(posedge CLK) disable iff (!rstN)
		npSel && (fsbReady || !berrN) |->
		(fsbReady != !berrN) && (state == iobPkg::xferIdle) && !secValid);

endmodule

/* tests/iobBridge_golden.txt */
# name op posted addr data ldsN udsN delay err expData result
# delay of 16 or more means the peripheral never answers
rdInit R 0 7f0003 0000 0 0 2 0 c333 ready
wrNp W 0 000005 1234 0 0 1 0 0000 ready
rdNp R 0 000005 0000 0 0 0 0 1234 ready
wrLo W 0 100005 00ab 0 1 3 0 0000 ready
rdLo R 0 000005 0000 0 0 1 0 12ab ready
wrHi W 0 000005 cd00 1 0 2 0 0000 ready
rdHi R 0 2a0005 0000 0 0 1 0 cdab ready
pw1 W 1 000007 1111 0 0 4 0 0000 ready
pw2 W 1 000007 2222 0 0 4 0 0000 ready
pw3 W 1 000007 3333 0 0 2 0 0000 ready
rdPw R 0 000007 0000 0 0 1 0 3333 ready
rdErr R 0 000002 0000 0 0 2 1 0000 berr
pwErr W 1 000008 5555 0 0 1 1 0000 ready
rdAfter R 0 000008 0000 0 0 1 0 c888 ready
wrErr W 0 000009 7777 0 0 1 1 0000 berr
rdTo R 0 000004 0000 0 0 20 0 0000 berr
rdNext R 0 000004 0000 0 0 1 0 c444 ready
wrTo W 0 00000a 9999 1 0 16 0 0000 berr
rdFin R 0 40000a 0000 0 0 0 0 caaa ready

/* tests/tbClock.sv */
`timescale 1ns/1ps

// Clock and reset source for the testbench
module tbClock (
	output logic CLK,
	output logic rstN
);

	// 10 ns period
	initial CLK = 1'b0;
	always #5 CLK = ~CLK;

	// Reset held low for three rising edges
	initial begin
		rstN = 1'b0;
		repeat (3) @(posedge CLK);
		#1 rstN = 1'b1;
	end

endmodule

/* tests/tbIobBridge.sv */
`timescale 1ns/1ps
`include "iobBridge_settings.svh"

module tbIobBridge;

	localparam int MaxLines = 32;

	logic CLK;
	logic rstN;
	logic asN;
	logic weN;
	logic ldsN;
	logic udsN;
	logic [`IOB_ADDR_W-1:0] fsbAddr;
	logic [`IOB_DATA_W-1:0] fsbWrData;
	logic [`IOB_DATA_W-1:0] fsbRdData;
	logic ioCs;
	logic ioPwCs;
	logic fsbReady;
	logic berrN;
	logic [`IOB_ADDR_W-1:0] ioAddr;
	logic [`IOB_DATA_W-1:0] ioWrData;
	logic [`IOB_DATA_W-1:0] ioRdData;
	logic ioRw;
	logic ioLds;
	logic ioUds;
	logic ioStrobe;
	logic ioAck;
	logic ioErr;

	// Golden lines
	string tName [MaxLines];
	logic tWrite [MaxLines];
	logic tPosted [MaxLines];
	logic [`IOB_ADDR_W-1:0] tAddr [MaxLines];
	logic [`IOB_DATA_W-1:0] tData [MaxLines];
	logic tLdsN [MaxLines];
	logic tUdsN [MaxLines];
	int tDelay [MaxLines];
	logic tErr [MaxLines];
	logic [`IOB_DATA_W-1:0] tExp [MaxLines];
	logic tExpBerr [MaxLines];
	int lineCount;
	logic loaded;

	// Peripheral model state
	logic [`IOB_DATA_W-1:0] mem [16];
	logic ackDone [MaxLines];
	int strobeIdx;
	int waitCnt;
	logic seen;

	tbClock uClock (
		.CLK  (CLK),
		.rstN (rstN)
	);

	iobBridge u_dut (
		.CLK       (CLK),
		.rstN      (rstN),
		.asN       (asN),
		.weN       (weN),
		.ldsN      (ldsN),
		.udsN      (udsN),
		.fsbAddr   (fsbAddr),
		.fsbWrData (fsbWrData),
		.fsbRdData (fsbRdData),
		.ioCs      (ioCs),
		.ioPwCs    (ioPwCs),
		.fsbReady  (fsbReady),
		.berrN     (berrN),
		.ioAddr    (ioAddr),
		.ioWrData  (ioWrData),
		.ioRdData  (ioRdData),
		.ioRw      (ioRw),
		.ioLds     (ioLds),
		.ioUds     (ioUds),
		.ioStrobe  (ioStrobe),
		.ioAck     (ioAck),
		.ioErr     (ioErr)
	);

	task automatic checkValue(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			$display("FAILED %s expected %0h actual %0h", what, expected, actual);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	task automatic loadGolden();
		int fd;
		int n;
		string line;
		logic [7:0] opC;
		logic [8*8-1:0] res;
		fd = $fopen("tests/iobBridge_golden.txt", "r");
		if (fd == 0) begin
			$display("cannot open the golden file");
			$display("tests failed");
			$fatal(1);
		end
		lineCount = 0;
		while (!$feof(fd) && lineCount < MaxLines) begin
			n = $fgets(line, fd);
			// Skip comments and blank lines
			if (n > 1 && line.getc(0) != "#") begin
				n = $sscanf(line, "%s %s %d %h %h %d %d %d %d %h %s",
					tName[lineCount], opC, tPosted[lineCount], tAddr[lineCount],
					tData[lineCount], tLdsN[lineCount], tUdsN[lineCount],
					tDelay[lineCount], tErr[lineCount], tExp[lineCount], res);
				if (n != 11) begin
					$display("golden file line %0d has missing fields", lineCount);
					$display("tests failed");
					$fatal(1);
				end
				tWrite[lineCount] = (opC == "W");
				tExpBerr[lineCount] = (res == "berr");
				ackDone[lineCount] = 1'b0;
				lineCount++;
			end
		end
		$fclose(fd);
	endtask

	// Word memory indexed by the low address bits
	assign ioRdData = mem[ioAddr[3:0]];

	// Peripheral answers one strobe per golden line, in order
	always @(posedge CLK) begin
		#1;
		if (ioAck || ioErr) begin
			// DUT sampled the answer at this edge
			ioAck = 1'b0;
			ioErr = 1'b0;
			seen = 1'b0;
		end else if (ioStrobe) begin
			if (!seen) begin
				seen = 1'b1;
				waitCnt = 0;
				// Cycle must match the next line in program order
				checkValue({tName[strobeIdx], ".ioAddr"}, tAddr[strobeIdx], ioAddr);
				checkValue({tName[strobeIdx], ".ioRw"}, !tWrite[strobeIdx], ioRw);
				checkValue({tName[strobeIdx], ".ioLds"}, !tLdsN[strobeIdx], ioLds);
				checkValue({tName[strobeIdx], ".ioUds"}, !tUdsN[strobeIdx], ioUds);
				if (tWrite[strobeIdx])
					checkValue({tName[strobeIdx], ".ioWrData"}, tData[strobeIdx], ioWrData);
				strobeIdx++;
			end
			if (waitCnt == tDelay[strobeIdx-1] && tDelay[strobeIdx-1] < `IOB_TIMEOUT) begin
				ackDone[strobeIdx-1] = 1'b1;
				if (tErr[strobeIdx-1]) begin
					ioErr = 1'b1;
				end else begin
					ioAck = 1'b1;
					// Byte lanes written only on a good acknowledge
					if (!ioRw && ioLds)
						mem[ioAddr[3:0]][7:0] = ioWrData[7:0];
					if (!ioRw && ioUds)
						mem[ioAddr[3:0]][15:8] = ioWrData[15:8];
				end
			end else begin
				waitCnt++;
			end
		end else begin
			// Strobe dropped by the master timeout
			seen = 1'b0;
		end
	end

	// Bounded by the number of lines
	initial begin
		wait (loaded);
		repeat (lineCount * (`IOB_TIMEOUT + 20) + 20) @(posedge CLK);
		$display("watchdog expired, the bridge hung");
		$display("tests failed");
		$fatal(1);
	end

	initial begin
		logic gotBerr;
		asN = 1'b1;
		weN = 1'b1;
		ldsN = 1'b1;
		udsN = 1'b1;
		fsbAddr = '0;
		fsbWrData = '0;
		ioCs = 1'b0;
		ioPwCs = 1'b0;
		ioAck = 1'b0;
		ioErr = 1'b0;
		seen = 1'b0;
		waitCnt = 0;
		strobeIdx = 0;
		loaded = 1'b0;
		for (int i = 0; i < 16; i++)
			mem[i] = 16'hC000 | (16'(i) * 16'h0111);
		loadGolden();
		loaded = 1'b1;
		wait (rstN);
		repeat (2) @(posedge CLK);

		for (int k = 0; k < lineCount; k++) begin
			@(posedge CLK);
			#1;
			asN = 1'b0;
			weN = !tWrite[k];
			ldsN = tLdsN[k];
			udsN = tUdsN[k];
			fsbAddr = tAddr[k];
			fsbWrData = tData[k];
			ioCs = 1'b1;
			ioPwCs = tPosted[k];
			// Sample at the falling edge, away from DUT updates
			do
				@(negedge CLK);
			while (!fsbReady && berrN);
			gotBerr = !berrN;
			checkValue({tName[k], ".berr"}, tExpBerr[k], gotBerr);
			checkValue({tName[k], ".ready"}, !tExpBerr[k], fsbReady);
			if (!tWrite[k] && !tExpBerr[k])
				checkValue({tName[k], ".rdData"}, tExp[k], fsbRdData);
			// Posted write released before the peripheral answered
			if (tPosted[k])
				checkValue({tName[k], ".early"}, 0, ackDone[k]);
			@(posedge CLK);
			#1;
			asN = 1'b1;
			weN = 1'b1;
			ioCs = 1'b0;
			ioPwCs = 1'b0;
			repeat (2) @(posedge CLK);
		end

		wait (!ioStrobe);
		repeat (4) @(posedge CLK);
		checkValue("strobeCount", lineCount, strobeIdx);
		$display("all tests passed");
		$finish;
	end

endmodule
